// File: Makefile
# Verilator simulation of the UART host bridge

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run tb_host_bridge with Verilator"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_host_bridge -Mdir obj_dir -f list.f
	@out=$$(./obj_dir/Vtb_host_bridge); \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir

// File: list.f
rtl/uart_pkg.sv
rtl/host_pkg.sv
rtl/uart_link_if.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/host_cmd_ctrl.sv
rtl/host_bridge_top.sv
sim/tb_host_bridge.sv

// File: rtl/host_bridge_top.sv
`timescale 1ns/1ps
`default_nettype none

module host_bridge_top
    import host_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    // Serial line to host
    input  logic        uart_rx,
    output logic        uart_tx,

    // Unified buffer
    output logic        ub_wr_en,
    output ub_addr_t    ub_wr_addr,
    output ub_word_t    ub_wr_data,
    output logic        ub_rd_en,
    output ub_addr_t    ub_rd_addr,
    input  ub_word_t    ub_rd_data,
    input  logic        ub_rd_valid,

    // Weight memory
    output logic        wt_wr_en,
    output wt_addr_t    wt_wr_addr,
    output wt_word_t    wt_wr_data,

    // Instruction buffer
    output logic        instr_wr_en,
    output instr_addr_t instr_wr_addr,
    output instr_word_t instr_wr_data,

    // Control and status
    output logic        start_execution,
    input  logic        sys_busy,
    input  logic        sys_done,
    input  logic        vpu_busy,
    input  logic        vpu_done,
    input  logic        ub_busy,
    input  logic        ub_done
);

    uart_link_if link ();

    uart_rx u_rx (.clk(clk), .rst_n(rst_n), .rx(uart_rx), .link(link));

    uart_tx u_tx (.clk(clk), .rst_n(rst_n), .tx(uart_tx), .link(link));

    host_cmd_ctrl u_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .link            (link),
        .ub_wr_en        (ub_wr_en),
        .ub_wr_addr      (ub_wr_addr),
        .ub_wr_data      (ub_wr_data),
        .ub_rd_en        (ub_rd_en),
        .ub_rd_addr      (ub_rd_addr),
        .ub_rd_data      (ub_rd_data),
        .ub_rd_valid     (ub_rd_valid),
        .wt_wr_en        (wt_wr_en),
        .wt_wr_addr      (wt_wr_addr),
        .wt_wr_data      (wt_wr_data),
        .instr_wr_en     (instr_wr_en),
        .instr_wr_addr   (instr_wr_addr),
        .instr_wr_data   (instr_wr_data),
        .start_execution (start_execution),
        .sys_busy        (sys_busy),
        .sys_done        (sys_done),
        .vpu_busy        (vpu_busy),
        .vpu_done        (vpu_done),
        .ub_busy         (ub_busy),
        .ub_done         (ub_done)
    );

endmodule

`default_nettype wire

// File: rtl/host_cmd_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module host_cmd_ctrl
    import uart_pkg::*;
    import host_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    uart_link_if.ctrl_side link,

    output logic          ub_wr_en,
    output ub_addr_t      ub_wr_addr,
    output ub_word_t      ub_wr_data,
    output logic          ub_rd_en,
    output ub_addr_t      ub_rd_addr,
    input  ub_word_t      ub_rd_data,
    input  logic          ub_rd_valid,

    output logic          wt_wr_en,
    output wt_addr_t      wt_wr_addr,
    output wt_word_t      wt_wr_data,

    output logic          instr_wr_en,
    output instr_addr_t   instr_wr_addr,
    output instr_word_t   instr_wr_data,

    output logic          start_execution,
    input  logic          sys_busy,
    input  logic          sys_done,
    input  logic          vpu_busy,
    input  logic          vpu_done,
    input  logic          ub_busy,
    input  logic          ub_done
);

    ctrl_state_e state;
    opcode_e     cmd;        // Opcode of the frame in progress
    opcode_e     rx_op;
    logic [15:0] addr;       // Word address, bumps per word
    frame_len_t  len;
    frame_len_t  len_next;
    frame_len_t  cnt;        // Bytes taken or sent
    logic        rx_ok;      // Good byte this cycle
    logic        last_byte;
    logic        tx_accept;
    uart_byte_t  status_byte;

    // Packers and read buffer
    ub_word_t    ub_buf, ub_next, rd_buf;
    wt_word_t    wt_buf, wt_next;
    instr_word_t instr_buf;
    logic        ub_take, ub_flush, wt_take, wt_flush, instr_take;

    assign rx_op       = opcode_e'(link.rx_data);
    assign rx_ok       = link.rx_valid && !link.rx_err;
    assign len_next    = {len[15:8], link.rx_data};
    assign last_byte   = (cnt + 16'd1 == len);
    assign tx_accept   = link.tx_valid && link.tx_ready;
    assign status_byte = {2'b00, ub_done, ub_busy, vpu_done, vpu_busy, sys_done, sys_busy};
    assign ub_rd_addr  = addr[8:0];  // Held steady while ub_rd_en

    // ======================================
    // Word packing
    // ======================================
    // UB byte k lands at 8k, weights fill from the top byte down
    assign ub_next  = ub_buf | (ub_word_t'(link.rx_data) << {cnt[4:0], 3'b000});
    assign wt_next  = wt_buf | (wt_word_t'(link.rx_data) << {~cnt[2:0], 3'b000});
    assign ub_take  = (state == st_write_ub) && rx_ok;
    assign wt_take  = (state == st_write_wt) && rx_ok;
    assign ub_flush = (cnt[4:0] == 5'(ub_bytes - 1)) || last_byte;
    assign wt_flush = (cnt[2:0] == 3'(wt_bytes - 1)) || last_byte;
    assign instr_take = (state == st_write_instr) && rx_ok;

    always_ff @(posedge clk) begin
        if (state == st_len_lo) begin
            ub_buf <= '0;  // Missing bytes of a short word read as zero
            wt_buf <= '0;
        end
        if (ub_take) begin
            ub_wr_addr <= addr[8:0];
            ub_wr_data <= ub_next;
            ub_buf     <= ub_flush ? '0 : ub_next;
        end
        if (wt_take) begin
            wt_wr_addr <= addr[9:0];
            wt_wr_data <= wt_next;
            wt_buf     <= wt_flush ? '0 : wt_next;
        end
        if (instr_take) begin
            instr_buf     <= {instr_buf[23:0], link.rx_data};  // First byte ends on top
            instr_wr_addr <= addr[4:0];
            instr_wr_data <= {instr_buf[23:0], link.rx_data};
        end
        if (state == st_read_wait && ub_rd_valid) begin
            rd_buf <= ub_rd_data;
        end else if (state == st_read_send && tx_accept) begin
            rd_buf <= rd_buf >> 8;  // Next byte to LSB
        end
    end

    // ======================================
    // Command FSM
    // ======================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state           <= st_idle;
            cmd             <= op_execute;
            addr            <= '0;
            len             <= '0;
            cnt             <= '0;
            ub_wr_en        <= 1'b0;
            wt_wr_en        <= 1'b0;
            instr_wr_en     <= 1'b0;
            ub_rd_en        <= 1'b0;
            start_execution <= 1'b0;
            link.tx_valid   <= 1'b0;
            link.tx_data    <= '0;
        end else begin
            ub_wr_en        <= 1'b0;  // Strobes last one cycle
            wt_wr_en        <= 1'b0;
            instr_wr_en     <= 1'b0;
            start_execution <= 1'b0;
            case (state)
                st_idle: if (rx_ok) begin
                    cnt <= '0;
                    case (rx_op)
                        op_write_ub, op_write_wt, op_write_instr, op_read_ub: begin
                            cmd   <= rx_op;
                            state <= st_addr_hi;
                        end
                        op_execute: start_execution <= 1'b1;  // No reply
                        op_read_status: begin
                            link.tx_data  <= status_byte;  // Sampled at the opcode
                            link.tx_valid <= 1'b1;
                            state         <= st_reply;
                        end
                        default: begin
                            link.tx_data  <= reply_err;
                            link.tx_valid <= 1'b1;
                            state         <= st_reply;
                        end
                    endcase
                end
                st_addr_hi: if (rx_ok) begin
                    addr[15:8] <= link.rx_data;
                    state      <= st_addr_lo;
                end
                st_addr_lo: if (rx_ok) begin
                    addr[7:0] <= link.rx_data;
                    state     <= (cmd == op_write_instr) ? st_write_instr : st_len_hi;
                end
                st_len_hi: if (rx_ok) begin
                    len[15:8] <= link.rx_data;
                    state     <= st_len_lo;
                end
                st_len_lo: if (rx_ok) begin
                    len <= len_next;
                    if (len_next == '0) begin
                        // Empty transfer: ack for writes, silence for reads
                        if (cmd == op_read_ub) begin
                            state <= st_idle;
                        end else begin
                            link.tx_data  <= (cmd == op_write_ub) ? ack_ub : ack_wt;
                            link.tx_valid <= 1'b1;
                            state         <= st_reply;
                        end
                    end else if (cmd == op_write_ub) begin
                        state <= st_write_ub;
                    end else if (cmd == op_write_wt) begin
                        state <= st_write_wt;
                    end else begin
                        ub_rd_en <= 1'b1;  // First word fetch
                        state    <= st_read_wait;
                    end
                end
                st_write_ub, st_write_wt: if (rx_ok) begin
                    cnt <= cnt + 16'd1;
                    if ((state == st_write_ub) ? ub_flush : wt_flush) begin
                        ub_wr_en <= (state == st_write_ub);
                        wt_wr_en <= (state == st_write_wt);
                        addr     <= addr + 16'd1;
                    end
                    if (last_byte) begin
                        link.tx_data  <= (state == st_write_ub) ? ack_ub : ack_wt;
                        link.tx_valid <= 1'b1;
                        state         <= st_reply;
                    end
                end
                st_write_instr: if (rx_ok) begin
                    cnt <= cnt + 16'd1;
                    if (cnt[1:0] == 2'(instr_bytes - 1)) begin
                        instr_wr_en <= 1'b1;  // No reply for instructions
                        state       <= st_idle;
                    end
                end
                st_read_wait: if (ub_rd_valid) begin
                    ub_rd_en <= 1'b0;
                    state    <= st_read_send;
                end
                st_read_send: begin
                    if (!link.tx_valid) begin
                        link.tx_data  <= rd_buf[7:0];
                        link.tx_valid <= 1'b1;
                    end else if (link.tx_ready) begin
                        link.tx_valid <= 1'b0;
                        cnt           <= cnt + 16'd1;
                        if (last_byte) begin
                            state <= st_idle;
                        end else if (cnt[4:0] == 5'(ub_bytes - 1)) begin
                            addr     <= addr + 16'd1;  // Word drained, fetch next
                            ub_rd_en <= 1'b1;
                            state    <= st_read_wait;
                        end
                    end
                end
                st_reply: if (link.tx_ready) begin
                    link.tx_valid <= 1'b0;  // Byte taken
                    state         <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Writes and reads share the unified buffer port pair
    assert property (@(posedge clk) disable iff (!rst_n) !(ub_wr_en && ub_rd_en));

    // Offered byte is never withdrawn
    assert property (@(posedge clk) disable iff (!rst_n)
        link.tx_valid && !link.tx_ready |=> link.tx_valid);

endmodule

`default_nettype wire

// File: rtl/host_pkg.sv
`default_nettype none

package host_pkg;

    // ======================================
    // Host command set
    // ======================================
    typedef enum logic [7:0] {
        op_write_ub    = 8'h01,  // Payload into unified buffer
        op_write_wt    = 8'h02,  // Payload into weight memory
        op_write_instr = 8'h03,  // One instruction word
        op_read_ub     = 8'h04,  // Stream unified buffer back
        op_execute     = 8'h05,  // Start strobe only
        op_read_status = 8'h06   // One status byte back
    } opcode_e;

    typedef enum logic [3:0] {
        st_idle, st_addr_hi, st_addr_lo, st_len_hi, st_len_lo,
        st_write_ub, st_write_wt, st_write_instr,
        st_read_wait, st_read_send, st_reply
    } ctrl_state_e;

    // Reply bytes
    localparam logic [7:0] ack_ub    = 8'hAA;
    localparam logic [7:0] ack_wt    = 8'hBB;
    localparam logic [7:0] reply_err = 8'hFF;  // Unknown opcode

    // ======================================
    // Memory geometry
    // ======================================
    localparam int ub_bytes    = 32;
    localparam int wt_bytes    = 8;
    localparam int instr_bytes = 4;

    typedef logic [8*ub_bytes-1:0]    ub_word_t;
    typedef logic [8*wt_bytes-1:0]    wt_word_t;
    typedef logic [8*instr_bytes-1:0] instr_word_t;

    typedef logic [8:0]  ub_addr_t;
    typedef logic [9:0]  wt_addr_t;
    typedef logic [4:0]  instr_addr_t;
    typedef logic [15:0] frame_len_t;  // Byte count of one transfer

endpackage

`default_nettype wire

// File: rtl/uart_link_if.sv
`timescale 1ns/1ps
`default_nettype none

interface uart_link_if
    import uart_pkg::*;
();

    // Receive side
    uart_byte_t rx_data;   // Valid only with rx_valid
    logic       rx_valid;  // One pulse per byte
    logic       rx_err;    // Stop bit was low

    // Transmit side
    uart_byte_t tx_data;
    logic       tx_valid;  // Held until tx_ready
    logic       tx_ready;  // Line idle

    modport rx_side (output rx_data, rx_valid, rx_err);
    modport tx_side (input tx_data, tx_valid, output tx_ready);
    modport ctrl_side (
        input  rx_data, rx_valid, rx_err, tx_ready,
        output tx_data, tx_valid
    );

endinterface

`default_nettype wire

// File: rtl/uart_pkg.sv
`default_nettype none

package uart_pkg;

    // ======================================
    // Serial line timing
    // ======================================
    // Kept short so a frame takes 80 clocks in simulation
    localparam logic [15:0] clks_per_bit = 16'd8;

    // ======================================
    // Data types
    // ======================================
    typedef logic [7:0] uart_byte_t;  // One data byte on the line

endpackage

`default_nettype wire

// File: rtl/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx
    import uart_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         rx,
    uart_link_if.rx_side link
);

    typedef enum logic [1:0] {s_idle, s_start, s_bits, s_stop} rx_state_e;

    rx_state_e   state;
    logic [2:0]  sync;     // Two sync flops plus one for edge detect
    logic        line;     // Synchronized line level
    logic [15:0] tick;     // Clocks into current bit
    logic [2:0]  bit_idx;
    uart_byte_t  shreg;

    assign line         = sync[1];
    assign link.rx_data = shreg;  // Stable through stop bit

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync          <= 3'b111;  // Idle line is high
            state         <= s_idle;
            tick          <= '0;
            bit_idx       <= '0;
            shreg         <= '0;
            link.rx_valid <= 1'b0;
            link.rx_err   <= 1'b0;
        end else begin
            sync          <= {sync[1:0], rx};
            link.rx_valid <= 1'b0;
            tick          <= tick + 16'd1;
            case (state)
                s_idle: begin
                    tick <= '0;
                    // Needs a high-to-low edge so a low stop bit cannot retrigger
                    if (sync[2] && !line) begin
                        state <= s_start;
                    end
                end
                s_start: if (tick == (clks_per_bit >> 1) - 16'd1) begin  // Mid start bit
                    tick    <= '0;
                    bit_idx <= '0;
                    state   <= line ? s_idle : s_bits;  // Glitch rejected
                end
                s_bits: if (tick == clks_per_bit - 16'd1) begin
                    tick    <= '0;
                    shreg   <= {line, shreg[7:1]};  // LSB first
                    bit_idx <= bit_idx + 3'd1;
                    if (bit_idx == 3'd7) begin
                        state <= s_stop;
                    end
                end
                s_stop: if (tick == clks_per_bit - 16'd1) begin
                    // Mid stop bit
                    link.rx_valid <= 1'b1;
                    link.rx_err   <= !line;  // Framing error
                    state         <= s_idle;
                end
                default: state <= s_idle;
            endcase
        end
    end

    // A byte takes ten bit times so pulses can never touch
    assert property (@(posedge clk) disable iff (!rst_n)
        link.rx_valid |=> !link.rx_valid);

endmodule

`default_nettype wire

// File: rtl/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx
    import uart_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    output logic         tx,
    uart_link_if.tx_side link
);

    logic        busy;     // Frame on the line
    logic [15:0] tick;     // Clocks into current bit
    logic [3:0]  bit_cnt;  // Bits finished so far
    logic [8:0]  shreg;    // Remaining data bits and stop bit

    assign link.tx_ready = !busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            tx      <= 1'b1;  // Idle high
            tick    <= '0;
            bit_cnt <= '0;
            shreg   <= '1;
        end else if (!busy) begin
            if (link.tx_valid) begin
                // Start bit goes out the cycle after acceptance
                busy    <= 1'b1;
                tx      <= 1'b0;
                tick    <= '0;
                bit_cnt <= '0;
                shreg   <= {1'b1, link.tx_data};
            end
        end else if (tick == clks_per_bit - 16'd1) begin
            tick <= '0;
            if (bit_cnt == 4'd9) begin
                busy <= 1'b0;  // End of stop bit
            end else begin
                tx      <= shreg[0];  // LSB first then stop
                shreg   <= {1'b1, shreg[8:1]};
                bit_cnt <= bit_cnt + 4'd1;
            end
        end else begin
            tick <= tick + 16'd1;
        end
    end

endmodule

`default_nettype wire

// File: sim/tb_host_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module tb_host_bridge
    import uart_pkg::*;
    import host_pkg::*;
();

    localparam int byte_wait  = 200;  // Cycles allowed per reply byte
    localparam int pulse_wait = 200;

    integer seed = 71;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        uart_rx;
    logic        uart_tx;
    logic        ub_wr_en, ub_rd_en, ub_rd_valid;
    ub_addr_t    ub_wr_addr, ub_rd_addr;
    ub_word_t    ub_wr_data, ub_rd_data;
    logic        wt_wr_en;
    wt_addr_t    wt_wr_addr;
    wt_word_t    wt_wr_data;
    logic        instr_wr_en;
    instr_addr_t instr_wr_addr;
    instr_word_t instr_wr_data;
    logic        start_execution;
    logic        sys_busy, sys_done, vpu_busy, vpu_done, ub_busy, ub_done;

    // Model memory and captured traffic
    ub_word_t    ub_mem [512];
    uart_byte_t  payload[$];
    uart_byte_t  rx_q[$];  // Decoded from uart_tx
    ub_addr_t    ub_addr_q[$], rd_addr_q[$];
    ub_word_t    ub_data_q[$];
    wt_addr_t    wt_addr_q[$];
    wt_word_t    wt_data_q[$];
    instr_addr_t instr_addr_q[$];
    instr_word_t instr_data_q[$];
    int          start_cnt = 0;

    host_bridge_top u_dut (.*);

    always #2 clk = ~clk;  // 4 ns period

    // ========================================
    // Helpers
    // ========================================
    task automatic fail_and_stop();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [255:0] got,
                               input logic [255:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
            fail_and_stop();
        end
    endtask

    function automatic int rand_range(input int lo, input int hi);
        int r;
        r = $random(seed);
        return lo + (r & 32'h7fff_ffff) % (hi - lo + 1);
    endfunction

    // One 8N1 frame with the stop bit level chosen by the caller
    task automatic send_byte(input uart_byte_t b, input logic stop_bit);
        logic [9:0] bits;
        bits = {stop_bit, b, 1'b0};
        for (int k = 0; k < 10; k++) begin
            @(posedge clk);
            uart_rx <= bits[k];
            repeat (clks_per_bit - 1) @(posedge clk);
        end
    endtask

    task automatic hold_line_high(input int n_bits);
        @(posedge clk);
        uart_rx <= 1'b1;
        repeat (n_bits * clks_per_bit) @(posedge clk);
    endtask

    // Opcode, address high/low, then length unless an instruction write
    task automatic send_head(input uart_byte_t op, input int addr, input int len);
        send_byte(op, 1'b1);
        send_byte(8'(addr >> 8), 1'b1);
        send_byte(8'(addr), 1'b1);
        if (op != 8'h03) begin
            send_byte(8'(len >> 8), 1'b1);
            send_byte(8'(len), 1'b1);
        end
    endtask

    task automatic make_payload(input int n);
        payload.delete();
        for (int i = 0; i < n; i++) begin
            payload.push_back(8'(rand_range(0, 255)));
        end
        foreach (payload[i]) send_byte(payload[i], 1'b1);
    endtask

    task automatic set_status(input logic [5:0] s);
        @(posedge clk);
        {ub_done, ub_busy, vpu_done, vpu_busy, sys_done, sys_busy} <= s;
    endtask

    task automatic wait_for_bytes(input int n);
        int waited;
        waited = 0;
        while (rx_q.size() < n && waited < byte_wait * n + 1000) begin
            @(posedge clk);
            waited++;
        end
        if (rx_q.size() < n) begin
            $display("Timeout at %0t ns: %0d of %0d serial bytes came back",
                     $time, rx_q.size(), n);
            fail_and_stop();
        end
    endtask

    task automatic settle();
        repeat (12 * clks_per_bit) @(posedge clk);  // Room for a stray extra byte
    endtask

    task automatic expect_reply(input uart_byte_t exp);
        wait_for_bytes(1);
        settle();
        check_value("reply count", 256'(rx_q.size()), 256'(1));
        check_value("uart_tx byte", 256'(rx_q.pop_front()), 256'(exp));
    endtask

    task automatic clear_captures();
        rx_q.delete();
        ub_addr_q.delete();
        ub_data_q.delete();
        rd_addr_q.delete();
        wt_addr_q.delete();
        wt_data_q.delete();
        instr_addr_q.delete();
        instr_data_q.delete();
        start_cnt = 0;
    endtask

    // ========================================
    // Monitors and memory model
    // ========================================
    initial begin
        uart_byte_t b;
        forever begin
            @(negedge clk);
            if (rst_n && !uart_tx) begin  // Start bit seen
                repeat (clks_per_bit / 2 - 1) @(negedge clk);
                for (int k = 0; k < 8; k++) begin
                    repeat (clks_per_bit) @(negedge clk);
                    b[k] = uart_tx;  // LSB first
                end
                repeat (clks_per_bit) @(negedge clk);
                if (!uart_tx) begin
                    $display("Error at %0t ns: uart_tx stop bit was low", $time);
                    fail_and_stop();
                end
                rx_q.push_back(b);
            end
        end
    end

    initial begin
        forever begin
            @(negedge clk);
            if (rst_n && ub_wr_en) begin
                ub_addr_q.push_back(ub_wr_addr);
                ub_data_q.push_back(ub_wr_data);
            end
            if (rst_n && wt_wr_en) begin
                wt_addr_q.push_back(wt_wr_addr);
                wt_data_q.push_back(wt_wr_data);
            end
            if (rst_n && instr_wr_en) begin
                instr_addr_q.push_back(instr_wr_addr);
                instr_data_q.push_back(instr_wr_data);
            end
            if (rst_n && start_execution) start_cnt++;
        end
    end

    // Answers a read 1 to 4 cycles late
    initial begin
        int delay;
        ub_rd_valid = 1'b0;
        ub_rd_data  = '0;
        forever begin
            @(negedge clk);
            if (rst_n && ub_rd_en) begin
                rd_addr_q.push_back(ub_rd_addr);
                delay = rand_range(1, 4);
                repeat (delay) @(posedge clk);
                ub_rd_data  <= ub_mem[ub_rd_addr];
                ub_rd_valid <= 1'b1;
                @(posedge clk);
                ub_rd_valid <= 1'b0;
            end
        end
    end

    // ========================================
    // Test sequence
    // ========================================
    initial begin
        int          base, n_len, n_words, waited;
        logic [5:0]  stat;
        uart_byte_t  op;
        ub_word_t    exp_ub;
        wt_word_t    exp_wt;
        ub_addr_t    a;
        rst_n   = 1'b0;
        uart_rx = 1'b1;  // Idle line
        {ub_done, ub_busy, vpu_done, vpu_busy, sys_done, sys_busy} = 6'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        repeat (4) @(posedge clk);

        // Write UB with byte k of a word at bits 8k+7:8k
        clear_captures();
        base  = rand_range(0, 65535);
        n_len = rand_range(1, 70);
        send_head(8'h01, base, n_len);
        make_payload(n_len);
        expect_reply(ack_ub);
        n_words = (n_len + ub_bytes - 1) / ub_bytes;
        check_value("ub_wr_en count", 256'(ub_addr_q.size()), 256'(n_words));
        for (int w = 0; w < n_words; w++) begin
            exp_ub = '0;  // Short last word padded with zeros
            for (int k = 0; k < ub_bytes && ub_bytes * w + k < n_len; k++) begin
                exp_ub[8*k +: 8] = payload[ub_bytes * w + k];
            end
            check_value("ub_wr_addr", 256'(ub_addr_q[w]), 256'(ub_addr_t'(base + w)));
            check_value("ub_wr_data", ub_data_q[w], exp_ub);
        end

        // Write weights with the first byte on top
        clear_captures();
        base  = rand_range(0, 65535);
        n_len = rand_range(1, 20);
        send_head(8'h02, base, n_len);
        make_payload(n_len);
        expect_reply(ack_wt);
        n_words = (n_len + wt_bytes - 1) / wt_bytes;
        check_value("wt_wr_en count", 256'(wt_addr_q.size()), 256'(n_words));
        for (int w = 0; w < n_words; w++) begin
            exp_wt = '0;
            for (int k = 0; k < wt_bytes && wt_bytes * w + k < n_len; k++) begin
                exp_wt[8*(wt_bytes-1-k) +: 8] = payload[wt_bytes * w + k];
            end
            check_value("wt_wr_addr", 256'(wt_addr_q[w]), 256'(wt_addr_t'(base + w)));
            check_value("wt_wr_data", 256'(wt_data_q[w]), 256'(exp_wt));
        end

        // Silent instruction write so the status byte is the only reply
        clear_captures();
        base = rand_range(0, 65535);
        stat = 6'(rand_range(0, 63));
        set_status(stat);
        send_head(8'h03, base, 0);
        make_payload(instr_bytes);
        send_byte(8'h06, 1'b1);
        expect_reply({2'b00, stat});
        check_value("instr_wr_en count", 256'(instr_addr_q.size()), 256'(1));
        check_value("instr_wr_addr", 256'(instr_addr_q[0]), 256'(instr_addr_t'(base)));
        check_value("instr_wr_data", 256'(instr_data_q[0]),
                    256'({payload[0], payload[1], payload[2], payload[3]}));

        // Read UB from a randomly filled memory
        for (int i = 0; i < 512; i++) begin
            for (int k = 0; k < ub_bytes / 4; k++) begin
                ub_mem[i][32*k +: 32] = $random(seed);
            end
        end
        clear_captures();
        base  = rand_range(0, 65535);
        n_len = rand_range(1, 70);
        send_head(8'h04, base, n_len);
        wait_for_bytes(n_len);
        settle();
        check_value("read byte count", 256'(rx_q.size()), 256'(n_len));
        n_words = (n_len + ub_bytes - 1) / ub_bytes;
        check_value("ub_rd_en count", 256'(rd_addr_q.size()), 256'(n_words));
        for (int w = 0; w < n_words; w++) begin
            check_value("ub_rd_addr", 256'(rd_addr_q[w]), 256'(ub_addr_t'(base + w)));
        end
        for (int i = 0; i < n_len; i++) begin
            a = ub_addr_t'(base + i / ub_bytes);
            check_value("uart_tx byte", 256'(rx_q.pop_front()),
                        256'(ub_mem[a][8*(i % ub_bytes) +: 8]));
        end

        // Execute gives one pulse and no reply
        clear_captures();
        send_byte(8'h05, 1'b1);
        waited = 0;
        while (start_cnt == 0 && waited < pulse_wait) begin
            @(posedge clk);
            waited++;
        end
        if (start_cnt == 0) begin
            $display("Timeout at %0t ns: start_execution never pulsed", $time);
            fail_and_stop();
        end
        settle();
        check_value("start_execution count", 256'(start_cnt), 256'(1));
        check_value("reply count", 256'(rx_q.size()), 256'(0));

        // Status and an unknown opcode
        stat = 6'(rand_range(0, 63));
        set_status(stat);
        send_byte(8'h06, 1'b1);
        expect_reply({2'b00, stat});
        op = 8'(rand_range(7, 255));
        send_byte(op, 1'b1);
        expect_reply(reply_err);

        // Framing error dropped and the next good status answered once
        clear_captures();
        stat = 6'(rand_range(0, 63));
        set_status(stat);
        send_byte(8'h06, 1'b0);
        hold_line_high(2);  // Receiver needs a fresh falling edge
        send_byte(8'h06, 1'b1);
        expect_reply({2'b00, stat});

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire
